//--- common/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Word address width of both memory ports.
`define DMA_ADDR_W 16

`define DMA_DATA_W 32

// Width of the descriptor word count.
`define DMA_LEN_W 8

`define DMA_DESC_DEPTH 4
`define DMA_DATA_DEPTH 8

`endif

//--- common/dma_pkg.sv
package dma_pkg;

  `include "dma_settings.svh"

  // Direction of a copy job.
  typedef enum logic {
    DDR_TO_HOST = 1'b0,
    HOST_TO_DDR = 1'b1
  } dma_mode_e;

  typedef logic [`DMA_DATA_W-1:0] dma_data_t;

  // One copy request as written by the host.
  typedef struct packed {
    dma_mode_e               mode;
    logic [`DMA_ADDR_W-1:0] src_addr;
    logic [`DMA_ADDR_W-1:0] dst_addr;
    logic [`DMA_LEN_W-1:0]  len;
  } dma_desc_t;

  // The part of a descriptor that the writer and the mux need.
  typedef struct packed {
    dma_mode_e               mode;
    logic [`DMA_ADDR_W-1:0] dst_addr;
    logic [`DMA_LEN_W-1:0]  len;
  } dma_job_t;

endpackage

//--- common/wb_pkg.sv
package wb_pkg;

  `include "dma_settings.svh"

  // Wishbone classic master to slave signals.
  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [`DMA_ADDR_W-1:0] adr;
    logic [`DMA_DATA_W-1:0] dat_w;
  } wb_req_t;

  // Wishbone classic slave to master signals.
  typedef struct packed {
    logic                    ack;
    logic [`DMA_DATA_W-1:0] dat_r;
  } wb_rsp_t;

endpackage

//--- source/dma_fifo.sv
`timescale 1ns/1ps

module dma_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     full,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full     = count == CNT_W'(DEPTH);
  assign empty    = count == '0;
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

//--- dma_engine/dma_reader.sv
`timescale 1ns/1ps

`include "dma_settings.svh"

module dma_reader (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                desc_empty,
  input  dma_pkg::dma_desc_t  desc,
  output logic                desc_pop,
  input  logic                writer_idle,
  output logic                job_start,
  output dma_pkg::dma_job_t   job,
  output wb_pkg::wb_req_t     rd_req,
  input  wb_pkg::wb_rsp_t     rd_rsp,
  input  logic                fifo_full,
  output logic                fifo_push,
  output dma_pkg::dma_data_t  fifo_data
);

  typedef enum logic {
    RD_IDLE,
    RD_READ
  } rd_state_e;

  rd_state_e              state;
  logic [`DMA_ADDR_W-1:0] addr;
  logic [`DMA_LEN_W-1:0]  remaining;
  logic                   word_done;

  // A job starts only once the writer has finished the previous one.
  assign job_start = (state == RD_IDLE) && !desc_empty && writer_idle;
  assign desc_pop  = job_start;
  assign job       = '{mode: desc.mode, dst_addr: desc.dst_addr, len: desc.len};

  // The strobe is held off while the FIFO is full. Only an acked read can
  // fill it, so a raised strobe stays up until its ack.
  always_comb begin
    rd_req     = '0;
    rd_req.cyc = (state == RD_READ) && !fifo_full;
    rd_req.stb = (state == RD_READ) && !fifo_full;
    rd_req.adr = addr;
  end

  assign word_done = rd_req.stb && rd_rsp.ack;
  assign fifo_push = word_done;
  assign fifo_data = rd_rsp.dat_r;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= RD_IDLE;
      remaining <= '0;
    end else if (job_start) begin
      state     <= RD_READ;
      remaining <= desc.len;
    end else if (word_done) begin
      remaining <= remaining - 1'b1;
      if (remaining == `DMA_LEN_W'(1)) begin
        state <= RD_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (job_start) begin
      addr <= desc.src_addr;
    end else if (word_done) begin
      addr <= addr + 1'b1;
    end
  end

endmodule

//--- dma_engine/dma_writer.sv
`timescale 1ns/1ps

`include "dma_settings.svh"

module dma_writer (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                job_start,
  input  dma_pkg::dma_job_t   job,
  input  logic                fifo_empty,
  input  dma_pkg::dma_data_t  fifo_data,
  output logic                fifo_pop,
  output wb_pkg::wb_req_t     wr_req,
  input  wb_pkg::wb_rsp_t     wr_rsp,
  output logic                idle,
  output logic                done
);

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_WAIT,
    WR_WRITE
  } wr_state_e;

  wr_state_e              state;
  logic [`DMA_ADDR_W-1:0] addr;
  logic [`DMA_LEN_W-1:0]  remaining;
  dma_pkg::dma_data_t     data_q;
  logic                   word_done;
  logic                   last_word;

  assign fifo_pop  = (state == WR_WAIT) && !fifo_empty;
  assign word_done = (state == WR_WRITE) && wr_rsp.ack;
  assign last_word = remaining == `DMA_LEN_W'(1);
  assign idle      = state == WR_IDLE;

  always_comb begin
    wr_req       = '0;
    wr_req.cyc   = state == WR_WRITE;
    wr_req.stb   = state == WR_WRITE;
    wr_req.we    = state == WR_WRITE;
    wr_req.adr   = addr;
    wr_req.dat_w = data_q;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= WR_IDLE;
      remaining <= '0;
      done      <= 1'b0;
    end else begin
      done <= word_done && last_word;
      case (state)
        WR_IDLE: begin
          if (job_start) begin
            state     <= WR_WAIT;
            remaining <= job.len;
          end
        end
        WR_WAIT: begin
          if (!fifo_empty) begin
            state <= WR_WRITE;
          end
        end
        default: begin
          if (word_done) begin
            remaining <= remaining - 1'b1;
            state     <= last_word ? WR_IDLE : WR_WAIT;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (job_start && idle) begin
      addr <= job.dst_addr;
    end else if (word_done) begin
      addr <= addr + 1'b1;
    end
    if (fifo_pop) begin
      data_q <= fifo_data;
    end
  end

endmodule

//--- source/dma_wb_mux.sv
`timescale 1ns/1ps

module dma_wb_mux (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                job_start,
  input  dma_pkg::dma_mode_e  job_mode,
  input  wb_pkg::wb_req_t     rd_req,
  output wb_pkg::wb_rsp_t     rd_rsp,
  input  wb_pkg::wb_req_t     wr_req,
  output wb_pkg::wb_rsp_t     wr_rsp,
  output wb_pkg::wb_req_t     host_req,
  input  wb_pkg::wb_rsp_t     host_rsp,
  output wb_pkg::wb_req_t     ddr_req,
  input  wb_pkg::wb_rsp_t     ddr_rsp
);

  dma_pkg::dma_mode_e mode_q;

  // The mode is taken at job start and held for the whole job.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mode_q <= dma_pkg::DDR_TO_HOST;
    end else if (job_start) begin
      mode_q <= job_mode;
    end
  end

  always_comb begin
    if (mode_q == dma_pkg::HOST_TO_DDR) begin
      host_req = rd_req;
      rd_rsp   = host_rsp;
      ddr_req  = wr_req;
      wr_rsp   = ddr_rsp;
    end else begin
      ddr_req  = rd_req;
      rd_rsp   = ddr_rsp;
      host_req = wr_req;
      wr_rsp   = host_rsp;
    end
  end

endmodule

//--- source/dma_copy_top.sv
`timescale 1ns/1ps

`include "dma_settings.svh"

module dma_copy_top (
  input  logic            clk,
  input  logic            arst_n,
  input  wb_pkg::wb_req_t desc_req,
  output wb_pkg::wb_rsp_t desc_rsp,
  output wb_pkg::wb_req_t host_req,
  input  wb_pkg::wb_rsp_t host_rsp,
  output wb_pkg::wb_req_t ddr_req,
  input  wb_pkg::wb_rsp_t ddr_rsp,
  output logic            done,
  output logic            busy
);

  // The descriptor is wider than a data word, so its top bits are carried
  // in the low bits of adr.
  localparam int DESC_ADR_W = $bits(dma_pkg::dma_desc_t) - `DMA_DATA_W;

  dma_pkg::dma_desc_t desc_in;
  dma_pkg::dma_desc_t desc_head;
  logic               desc_ack_q;
  logic               desc_full;
  logic               desc_empty;
  logic               desc_pop;
  logic               job_start;
  dma_pkg::dma_job_t  job;
  logic               writer_idle;
  logic               fifo_push;
  dma_pkg::dma_data_t fifo_wdata;
  logic               fifo_full;
  logic               fifo_empty;
  logic               fifo_pop;
  dma_pkg::dma_data_t fifo_rdata;
  wb_pkg::wb_req_t    rd_req;
  wb_pkg::wb_rsp_t    rd_rsp;
  wb_pkg::wb_req_t    wr_req;
  wb_pkg::wb_rsp_t    wr_rsp;

  assign desc_in = {desc_req.adr[DESC_ADR_W-1:0], desc_req.dat_w};

  // Registered ack. The queue is written in the ack cycle while the master
  // still holds the descriptor.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      desc_ack_q <= 1'b0;
      busy       <= 1'b0;
    end else begin
      desc_ack_q <= desc_req.cyc && desc_req.stb && desc_req.we && !desc_full && !desc_ack_q;
      busy       <= desc_ack_q || !desc_empty || !writer_idle;
    end
  end

  assign desc_rsp = '{ack: desc_ack_q, dat_r: '0};

  dma_fifo #(.payload_t(dma_pkg::dma_desc_t), .DEPTH(`DMA_DESC_DEPTH)) desc_queue_inst (
    .clk(clk), .arst_n(arst_n), .push(desc_ack_q), .push_data(desc_in), .pop(desc_pop),
    .pop_data(desc_head), .full(desc_full), .empty(desc_empty)
  );

  dma_fifo #(.payload_t(dma_pkg::dma_data_t), .DEPTH(`DMA_DATA_DEPTH)) data_fifo_inst (
    .clk(clk), .arst_n(arst_n), .push(fifo_push), .push_data(fifo_wdata), .pop(fifo_pop),
    .pop_data(fifo_rdata), .full(fifo_full), .empty(fifo_empty)
  );

  dma_reader dma_reader_inst (
    .clk(clk), .arst_n(arst_n), .desc_empty(desc_empty), .desc(desc_head),
    .desc_pop(desc_pop), .writer_idle(writer_idle), .job_start(job_start), .job(job),
    .rd_req(rd_req), .rd_rsp(rd_rsp), .fifo_full(fifo_full), .fifo_push(fifo_push),
    .fifo_data(fifo_wdata)
  );

  dma_writer dma_writer_inst (
    .clk(clk), .arst_n(arst_n), .job_start(job_start), .job(job), .fifo_empty(fifo_empty),
    .fifo_data(fifo_rdata), .fifo_pop(fifo_pop), .wr_req(wr_req), .wr_rsp(wr_rsp),
    .idle(writer_idle), .done(done)
  );

  dma_wb_mux dma_wb_mux_inst (
    .clk(clk), .arst_n(arst_n), .job_start(job_start), .job_mode(job.mode),
    .rd_req(rd_req), .rd_rsp(rd_rsp), .wr_req(wr_req), .wr_rsp(wr_rsp),
    .host_req(host_req), .host_rsp(host_rsp), .ddr_req(ddr_req), .ddr_rsp(ddr_rsp)
  );

endmodule

//--- tb/dma_copy_assertions.sv
`timescale 1ns/1ps

module dma_copy_assertions (
  input logic            clk,
  input logic            arst_n,
  input wb_pkg::wb_req_t desc_req,
  input wb_pkg::wb_rsp_t desc_rsp,
  input wb_pkg::wb_req_t host_req,
  input wb_pkg::wb_rsp_t host_rsp,
  input wb_pkg::wb_req_t ddr_req,
  input wb_pkg::wb_rsp_t ddr_rsp
);

  host_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
    host_req.stb |-> host_req.cyc) else $error("host stb raised outside a cycle");

  ddr_stb_in_cyc: assert property (@(posedge clk) disable iff (!arst_n)
    ddr_req.stb |-> ddr_req.cyc) else $error("ddr stb raised outside a cycle");

  // One port reads while the other writes.
  single_writer: assert property (@(posedge clk) disable iff (!arst_n)
    !(host_req.we && ddr_req.we)) else $error("host and ddr both written");

  host_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (host_req.stb && !host_rsp.ack) |=> $stable(host_req))
    else $error("host request changed before ack");

  ddr_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (ddr_req.stb && !ddr_rsp.ack) |=> $stable(ddr_req))
    else $error("ddr request changed before ack");

  desc_ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
    desc_rsp.ack |-> $past(desc_req.cyc && desc_req.stb))
    else $error("descriptor ack without a request");

endmodule

bind dma_copy_top dma_copy_assertions dma_copy_assertions_inst (.*);

//--- tb/dma_copy_tb.sv
`timescale 1ns/1ps

`include "dma_settings.svh"

module dma_copy_tb;

  localparam int MEM_WORDS     = 256;
  localparam int TOTAL_WORDS   = 82;
  localparam int TIMEOUT_LIMIT = 16 + 20 * TOTAL_WORDS + 500;

  logic            clk = 1'b0;
  logic            arst_n;
  wb_pkg::wb_req_t desc_req;
  wb_pkg::wb_rsp_t desc_rsp;
  wb_pkg::wb_req_t host_req;
  wb_pkg::wb_rsp_t host_rsp;
  wb_pkg::wb_req_t ddr_req;
  wb_pkg::wb_rsp_t ddr_rsp;
  logic            done;
  logic            busy;

  // Index 0 is the host memory, index 1 the DDR memory.
  logic [`DMA_DATA_W-1:0] mem [2][MEM_WORDS];
  logic [`DMA_DATA_W-1:0] shadow [2][MEM_WORDS];
  wb_pkg::wb_req_t        port_req [2];
  wb_pkg::wb_rsp_t        port_rsp [2];
  logic                   port_pending [2];
  int                     port_wait [2];
  int                     stall_len [2];
  logic [7:0]             stall_adr [2];

  integer seed;
  int     errors        = 0;
  int     checks        = 0;
  int     cycle_count   = 0;
  int     done_count    = 0;
  int     expected_done = 0;
  logic   saw_full      = 1'b0;

  dma_copy_top dma_copy_top_inst (
    .clk(clk), .arst_n(arst_n), .desc_req(desc_req), .desc_rsp(desc_rsp),
    .host_req(host_req), .host_rsp(host_rsp), .ddr_req(ddr_req), .ddr_rsp(ddr_rsp),
    .done(done), .busy(busy)
  );

  always #5 clk = ~clk;

  assign port_req[0] = host_req;
  assign port_req[1] = ddr_req;
  assign host_rsp    = port_rsp[0];
  assign ddr_rsp     = port_rsp[1];

  function automatic logic [31:0] fill_word(int p, int a);
    return {4'(p + 1), 4'h0, 8'(a), 8'(a * 7 + 3), 8'(~a)};
  endfunction

  // Expected effect of one descriptor on both memories.
  function automatic void dma_copy_model(dma_pkg::dma_desc_t d);
    int src;
    int dst;
    src = (d.mode == dma_pkg::HOST_TO_DDR) ? 0 : 1;
    dst = 1 - src;
    for (int i = 0; i < int'(d.len); i++) begin
      shadow[dst][8'(int'(d.dst_addr) + i)] = shadow[src][8'(int'(d.src_addr) + i)];
    end
  endfunction

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERROR %s: actual %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic compare_memories();
    string name;
    for (int p = 0; p < 2; p++) begin
      for (int a = 0; a < MEM_WORDS; a++) begin
        name = $sformatf("%s[%02h]", (p == 0) ? "host_mem" : "ddr_mem", a);
        check_value(name, mem[p][a], shadow[p][a]);
      end
    end
  endtask

  // The descriptor's top bits ride in the low bits of adr.
  task automatic submit_desc(dma_pkg::dma_mode_e mode, int src, int dst, int len);
    dma_pkg::dma_desc_t d;
    d.mode     = mode;
    d.src_addr = `DMA_ADDR_W'(src);
    d.dst_addr = `DMA_ADDR_W'(dst);
    d.len      = `DMA_LEN_W'(len);
    dma_copy_model(d);
    desc_req       = '0;
    desc_req.cyc   = 1'b1;
    desc_req.stb   = 1'b1;
    desc_req.we    = 1'b1;
    desc_req.adr   = `DMA_ADDR_W'(d >> `DMA_DATA_W);
    desc_req.dat_w = d[`DMA_DATA_W-1:0];
    do @(negedge clk); while (!desc_rsp.ack);
    @(negedge clk);
    desc_req = '0;
  endtask

  task automatic wait_all_done();
    while (done_count < expected_done) @(posedge clk);
    @(negedge clk);
    check_value("busy", 32'(busy), 32'h0);
  endtask

  // Memory models. A request is acked after 0 to 3 idle cycles, or after a
  // longer stall when a write hits the armed stall address.
  initial begin
    for (int p = 0; p < 2; p++) begin
      port_rsp[p]     = '0;
      port_pending[p] = 1'b0;
      port_wait[p]    = 0;
      for (int a = 0; a < MEM_WORDS; a++) begin
        mem[p][a] = fill_word(p, a);
      end
    end
    forever begin
      @(negedge clk);
      for (int p = 0; p < 2; p++) begin
        if (port_rsp[p].ack) begin
          port_rsp[p].ack = 1'b0;
          port_pending[p] = 1'b0;
        end else if (port_req[p].cyc && port_req[p].stb) begin
          if (!port_pending[p]) begin
            port_pending[p] = 1'b1;
            port_wait[p]    = {$random(seed)} % 4;
            if (port_req[p].we && stall_len[p] != 0 &&
                port_req[p].adr[7:0] == stall_adr[p]) begin
              port_wait[p] = stall_len[p];
            end
          end
          if (port_wait[p] == 0) begin
            port_rsp[p].ack   = 1'b1;
            port_rsp[p].dat_r = mem[p][port_req[p].adr[7:0]];
            if (port_req[p].we) begin
              mem[p][port_req[p].adr[7:0]] = port_req[p].dat_w;
            end
          end else begin
            port_wait[p]--;
          end
        end
      end
    end
  end

  // Counts done pulses and compares both memories after the last one.
  always @(negedge clk) begin
    if (arst_n && done) begin
      done_count = done_count + 1;
      if (done_count == expected_done) begin
        check_value("busy", 32'(busy), 32'h1);
        compare_memories();
      end
    end
  end

  always @(posedge clk) begin
    if (dma_copy_top_inst.fifo_full) begin
      saw_full <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_LIMIT) begin
      $display("Timeout: the copies did not finish within %0d cycles", TIMEOUT_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    seed     = 57136;
    arst_n   = 1'b0;
    desc_req = '0;
    for (int p = 0; p < 2; p++) begin
      stall_len[p] = 0;
      stall_adr[p] = 8'h00;
      for (int a = 0; a < MEM_WORDS; a++) begin
        shadow[p][a] = fill_word(p, a);
      end
    end
    repeat (16) @(negedge clk);
    arst_n = 1'b1;

    // Nothing may move without a descriptor.
    repeat (20) begin
      @(negedge clk);
      check_value("host_req.cyc", 32'(host_req.cyc), 32'h0);
      check_value("ddr_req.cyc", 32'(ddr_req.cyc), 32'h0);
      check_value("desc_rsp.ack", 32'(desc_rsp.ack), 32'h0);
      check_value("done", 32'(done), 32'h0);
      check_value("busy", 32'(busy), 32'h0);
    end

    expected_done += 1;
    submit_desc(dma_pkg::HOST_TO_DDR, 'h10, 'h40, 12);
    wait_all_done();

    expected_done += 1;
    submit_desc(dma_pkg::DDR_TO_HOST, 'h80, 'h20, 10);
    wait_all_done();

    // Later jobs read what earlier ones wrote, so the order shows.
    expected_done += 4;
    submit_desc(dma_pkg::HOST_TO_DDR, 'h00, 'h90, 6);
    submit_desc(dma_pkg::DDR_TO_HOST, 'h90, 'hA0, 6);
    submit_desc(dma_pkg::HOST_TO_DDR, 'hA0, 'hB0, 6);
    submit_desc(dma_pkg::DDR_TO_HOST, 'hB0, 'hC0, 6);
    wait_all_done();

    // A long stall on the first DDR write fills the data FIFO.
    stall_adr[1] = 8'hD0;
    stall_len[1] = 40;
    expected_done += 2;
    submit_desc(dma_pkg::HOST_TO_DDR, 'h30, 'hD0, 20);
    submit_desc(dma_pkg::DDR_TO_HOST, 'h40, 'hE0, 16);
    wait_all_done();
    check_value("fifo_full_seen", 32'(saw_full), 32'h1);

    repeat (10) @(negedge clk);
    check_value("done_count", done_count, expected_done);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+common
common/dma_pkg.sv
common/wb_pkg.sv
source/dma_fifo.sv
dma_engine/dma_reader.sv
dma_engine/dma_writer.sv
source/dma_wb_mux.sv
source/dma_copy_top.sv
tb/dma_copy_assertions.sv
tb/dma_copy_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the DMA copy testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module dma_copy_tb -f all.f --Mdir "$OBJ" -o dma_copy_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$OBJ/dma_copy_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0
